// ==== logic/exec_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_macros.svh"

module exec_alu import rv_exec_pkg::*; (
    exec_operand_if.alu_mp opnd_i,
    input  exe_type_e      alusel_i,
    output alu_result_t    result_o
);
    uop_e                uop;
    logic [`SHAMT_W-1:0] shamt;
    logic [`XLEN-1:0]    rs1_add_imm;
    logic [`XLEN-1:0]    arith_res;
    logic [`XLEN-1:0]    logic_res;
    logic [`XLEN-1:0]    shift_res;
    logic [`XLEN-1:0]    link_res;
    logic [`XLEN-1:0]    rd_wd;
    logic [`XLEN-1:0]    mem_a;
    logic [`XLEN-1:0]    mem_wd;

    assign uop = uop_e'(opnd_i.uop);

    assign rs1_add_imm = opnd_i.rs1_d + opnd_i.imm;  // addi and load/store address

    always_comb begin
        case (uop)
            UOP_ADDI: arith_res = rs1_add_imm;
            UOP_ADD:  arith_res = opnd_i.rs1_d + opnd_i.rs2_d;
            UOP_SUB:  arith_res = opnd_i.rs1_d - opnd_i.rs2_d;
            default:  arith_res = '0;
        endcase
    end

    always_comb begin
        case (uop)
            UOP_LUI:   logic_res = opnd_i.imm;   // imm arrives already shifted up
            UOP_AUIPC: logic_res = opnd_i.pc + opnd_i.imm;
            UOP_ANDI:  logic_res = opnd_i.rs1_d & opnd_i.imm;
            UOP_ORI:   logic_res = opnd_i.rs1_d | opnd_i.imm;
            UOP_XORI:  logic_res = opnd_i.rs1_d ^ opnd_i.imm;
            UOP_AND:   logic_res = opnd_i.rs1_d & opnd_i.rs2_d;
            UOP_OR:    logic_res = opnd_i.rs1_d | opnd_i.rs2_d;
            UOP_XOR:   logic_res = opnd_i.rs1_d ^ opnd_i.rs2_d;
            UOP_SLTI:  logic_res = {{(`XLEN-1){1'b0}}, $signed(opnd_i.rs1_d) < $signed(opnd_i.imm)};
            UOP_SLTIU: logic_res = {{(`XLEN-1){1'b0}}, opnd_i.rs1_d < opnd_i.imm};
            UOP_SLT:   logic_res = {{(`XLEN-1){1'b0}}, $signed(opnd_i.rs1_d) < $signed(opnd_i.rs2_d)};
            UOP_SLTU:  logic_res = {{(`XLEN-1){1'b0}}, opnd_i.rs1_d < opnd_i.rs2_d};
            default:   logic_res = '0;
        endcase
    end

    // immediate shifts take shamt from imm, register shifts from rs2
    assign shamt = (uop == UOP_SLLI || uop == UOP_SRLI || uop == UOP_SRAI) ?
                   opnd_i.imm[`SHAMT_W-1:0] : opnd_i.rs2_d[`SHAMT_W-1:0];

    always_comb begin
        case (uop)
            UOP_SLLI, UOP_SLL: shift_res = opnd_i.rs1_d << shamt;
            UOP_SRLI, UOP_SRL: shift_res = opnd_i.rs1_d >> shamt;
            UOP_SRAI, UOP_SRA: shift_res = $unsigned($signed(opnd_i.rs1_d) >>> shamt);
            default:           shift_res = '0;
        endcase
    end

    // return address for jal/jalr
    assign link_res = (uop == UOP_JAL || uop == UOP_JALR) ? opnd_i.pc + `INSN_BYTES : '0;

    always_comb begin
        case (alusel_i)
            EXE_ARITH:  rd_wd = arith_res;
            EXE_LOGIC:  rd_wd = logic_res;
            EXE_SHIFT:  rd_wd = shift_res;
            EXE_BRANCH: rd_wd = link_res;
            default:    rd_wd = '0;
        endcase
    end

    always_comb begin
        mem_a  = '0;
        mem_wd = '0;
        case (uop)
            UOP_LB, UOP_LBU, UOP_LH, UOP_LHU, UOP_LW: begin
                mem_a = rs1_add_imm;
            end
            UOP_SB, UOP_SH, UOP_SW: begin
                mem_a  = rs1_add_imm;
                mem_wd = opnd_i.rs2_d;  // full word, lsu picks the byte lanes
            end
            default: begin
            end
        endcase
    end

    assign result_o = '{rd_wd: rd_wd, mem_a: mem_a, mem_wd: mem_wd};

endmodule

`default_nettype wire

// ==== logic/exec_branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_macros.svh"

module exec_branch_unit import rv_exec_pkg::*; (
    exec_operand_if.branch_mp opnd_i,
    input  logic [`XLEN-1:0]  next_pc_i,     // pc the front end fetched after this one
    input  logic              next_taken_i,  // front end predicted taken
    output branch_info_t      branch_o
);
    uop_e             uop;
    logic [`XLEN-1:0] pc_plus_4;
    logic [`XLEN-1:0] pc_add_imm;
    logic             rs1_eq_rs2;
    logic             rs1_lt_rs2_s;
    logic             rs1_lt_rs2_u;
    logic             rd_link;
    logic             rs1_link;
    logic             request;
    logic             taken;
    logic             is_call;
    logic             is_ret;
    logic             is_jmp;
    logic [`XLEN-1:0] target;
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;

    assign uop = uop_e'(opnd_i.uop);

    assign pc_plus_4  = opnd_i.pc + `INSN_BYTES;
    assign pc_add_imm = opnd_i.pc + opnd_i.imm;

    assign rs1_eq_rs2   = (opnd_i.rs1_d == opnd_i.rs2_d);
    assign rs1_lt_rs2_s = ($signed(opnd_i.rs1_d) < $signed(opnd_i.rs2_d));
    assign rs1_lt_rs2_u = (opnd_i.rs1_d < opnd_i.rs2_d);

    // x1 or x5
    assign rd_link  = (opnd_i.rd_a == `LINK_REG_RA) || (opnd_i.rd_a == `LINK_REG_T0);
    assign rs1_link = (opnd_i.rs1_a == `LINK_REG_RA) || (opnd_i.rs1_a == `LINK_REG_T0);

    always_comb begin
        request = 1'b1;
        taken   = 1'b0;
        is_call = 1'b0;
        is_ret  = 1'b0;
        is_jmp  = 1'b0;
        target  = pc_add_imm;
        case (uop)
            UOP_JAL: begin
                taken = 1'b1;
                if (rd_link) begin
                    is_call = 1'b1;
                end else begin
                    is_jmp = 1'b1;
                end
            end
            UOP_JALR: begin
                taken  = 1'b1;
                target = opnd_i.rs1_d + opnd_i.imm;   // bit 0 is kept as is
                if (rd_link && rs1_link) begin
                    is_call = 1'b1;
                    // pop only when returning through the other link register
                    is_ret  = (opnd_i.rd_a != opnd_i.rs1_a);
                end else if (rd_link) begin
                    is_call = 1'b1;
                end else if (rs1_link) begin
                    is_ret = 1'b1;
                end else begin
                    is_jmp = 1'b1;
                end
            end
            UOP_BEQ:  taken = rs1_eq_rs2;
            UOP_BNE:  taken = ~rs1_eq_rs2;
            UOP_BGE:  taken = ~rs1_lt_rs2_s;
            UOP_BGEU: taken = ~rs1_lt_rs2_u;
            UOP_BLT:  taken = rs1_lt_rs2_s;
            UOP_BLTU: taken = rs1_lt_rs2_u;
            default: begin
                request = 1'b0;   // not a control transfer
                target  = '0;
            end
        endcase
    end

    // compare the outcome with what the front end did
    always_comb begin
        redirect    = 1'b0;
        redirect_pc = '0;
        if (request) begin
            if (taken) begin
                if (!next_taken_i || (next_pc_i != target)) begin
                    redirect    = 1'b1;
                    redirect_pc = target;
                end
            end else if (next_taken_i) begin
                redirect    = 1'b1;   // fetched down the wrong path
                redirect_pc = pc_plus_4;
            end
        end
    end

    assign branch_o = '{
        request:     request,
        taken:       taken,
        is_call:     is_call,
        is_ret:      is_ret,
        is_jmp:      is_jmp,
        target:      target,
        redirect:    redirect,
        redirect_pc: redirect_pc
    };

endmodule

`default_nettype wire

// ==== logic/exec_mem_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_macros.svh"

// execute to memory stage register, one instruction per cycle
module exec_mem_reg import rv_exec_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic [`XLEN-1:0]       pc_i,
    input  uop_e                   uop_i,
    input  logic                   rd_we_i,
    input  logic [`REG_ADDR_W-1:0] rd_a_i,
    input  alu_result_t            alu_i,
    input  branch_info_t           branch_i,

    output logic [`XLEN-1:0]       pc_o,
    output uop_e                   uop_o,     // lsu decodes load/store from this
    output logic                   rd_we_o,
    output logic [`REG_ADDR_W-1:0] rd_a_o,
    output alu_result_t            alu_o,
    output branch_info_t           branch_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // memory stage sees a bubble
            pc_o     <= '0;
            uop_o    <= UOP_NOP;
            rd_we_o  <= 1'b0;
            rd_a_o   <= '0;
            alu_o    <= '0;
            branch_o <= '0;   // no request, no redirect
        end else begin
            pc_o     <= pc_i;
            uop_o    <= uop_i;
            rd_we_o  <= rd_we_i;
            rd_a_o   <= rd_a_i;
            alu_o    <= alu_i;
            branch_o <= branch_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/exec_operand_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_macros.svh"

// decoded operands of the instruction in execute
interface exec_operand_if;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       rs1_d;
    logic [`XLEN-1:0]       rs2_d;
    logic [`XLEN-1:0]       imm;
    logic [`UOP_W-1:0]      uop;    // raw code, units cast it to uop_e
    logic [`REG_ADDR_W-1:0] rd_a;
    logic [`REG_ADDR_W-1:0] rs1_a;

    modport alu_mp (input pc, rs1_d, rs2_d, imm, uop);

    // register indices are needed for the ras hints
    modport branch_mp (input pc, rs1_d, rs2_d, imm, uop, rd_a, rs1_a);
endinterface

`default_nettype wire

// ==== logic/rv_exec_macros.svh ====
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define SHAMT_W     5      // RV32 shifts use the low 5 bits only

// pc step for the link value and the fall-through pc
`define INSN_BYTES  4

// x1 (ra) and x5 (t0) are the link registers for ras hints
`define LINK_REG_RA 1
`define LINK_REG_T0 5

// micro-op code width, must hold every uop_e value
`define UOP_W       6

`endif

// ==== logic/rv_exec_pkg.sv ====
`default_nettype none

`include "rv_exec_macros.svh"

package rv_exec_pkg;

    // micro-ops handled by the execute stage
    typedef enum logic [`UOP_W-1:0] {
        UOP_NOP   = 6'h00,
        UOP_ADDI  = 6'h01, UOP_ADD   = 6'h02, UOP_SUB   = 6'h03,
        UOP_LUI   = 6'h04, UOP_AUIPC = 6'h05,
        UOP_ANDI  = 6'h06, UOP_ORI   = 6'h07, UOP_XORI  = 6'h08,
        UOP_AND   = 6'h09, UOP_OR    = 6'h0a, UOP_XOR   = 6'h0b,
        UOP_SLTI  = 6'h0c, UOP_SLTIU = 6'h0d, UOP_SLT   = 6'h0e, UOP_SLTU = 6'h0f,
        UOP_SLLI  = 6'h10, UOP_SRLI  = 6'h11, UOP_SRAI  = 6'h12,
        UOP_SLL   = 6'h13, UOP_SRL   = 6'h14, UOP_SRA   = 6'h15,
        UOP_LB    = 6'h16, UOP_LBU   = 6'h17, UOP_LH    = 6'h18, UOP_LHU  = 6'h19,
        UOP_LW    = 6'h1a,
        UOP_SB    = 6'h1b, UOP_SH    = 6'h1c, UOP_SW    = 6'h1d,
        UOP_JAL   = 6'h1e, UOP_JALR  = 6'h1f,
        UOP_BEQ   = 6'h20, UOP_BNE   = 6'h21, UOP_BGE   = 6'h22,
        UOP_BGEU  = 6'h23, UOP_BLT   = 6'h24, UOP_BLTU  = 6'h25
    } uop_e;

    // which unit result goes to rd
    typedef enum logic [2:0] {
        EXE_NONE   = 3'd0,
        EXE_ARITH  = 3'd1,
        EXE_LOGIC  = 3'd2,
        EXE_SHIFT  = 3'd3,
        EXE_BRANCH = 3'd4   // link value of jal/jalr
    } exe_type_e;

    typedef struct packed {
        logic [`XLEN-1:0] rd_wd;
        logic [`XLEN-1:0] mem_a;
        logic [`XLEN-1:0] mem_wd;
    } alu_result_t;

    typedef struct packed {
        logic             request;     // jump or branch in execute
        logic             taken;
        logic             is_call;     // ras push
        logic             is_ret;      // ras pop
        logic             is_jmp;
        logic [`XLEN-1:0] target;
        logic             redirect;    // front end must restart
        logic [`XLEN-1:0] redirect_pc;
    } branch_info_t;

endpackage

`default_nettype wire

// ==== logic/rv_exec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_macros.svh"

module rv_exec_top import rv_exec_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic [`XLEN-1:0]       pc_i,
    input  logic [`XLEN-1:0]       next_pc_i,
    input  logic                   next_taken_i,
    input  uop_e                   uop_i,
    input  exe_type_e              alusel_i,
    input  logic [`XLEN-1:0]       rs1_d_i,
    input  logic [`XLEN-1:0]       rs2_d_i,
    input  logic [`XLEN-1:0]       imm_i,
    input  logic [`REG_ADDR_W-1:0] rs1_a_i,
    input  logic                   rd_we_i,
    input  logic [`REG_ADDR_W-1:0] rd_a_i,

    output logic [`XLEN-1:0]       pc_o,
    output uop_e                   uop_o,
    output logic                   rd_we_o,
    output logic [`REG_ADDR_W-1:0] rd_a_o,
    output logic [`XLEN-1:0]       rd_wd_o,
    output logic [`XLEN-1:0]       mem_a_o,
    output logic [`XLEN-1:0]       mem_wd_o,
    output logic                   branch_request_o,
    output logic                   branch_taken_o,
    output logic                   branch_is_call_o,
    output logic                   branch_is_ret_o,
    output logic                   branch_is_jmp_o,
    output logic [`XLEN-1:0]       branch_target_o,
    output logic                   branch_redirect_o,
    output logic [`XLEN-1:0]       branch_redirect_pc_o
);
    alu_result_t  alu_res;
    alu_result_t  alu_q;
    branch_info_t br_info;
    branch_info_t br_q;

    exec_operand_if opnd ();

    assign opnd.pc    = pc_i;
    assign opnd.rs1_d = rs1_d_i;
    assign opnd.rs2_d = rs2_d_i;
    assign opnd.imm   = imm_i;
    assign opnd.uop   = uop_i;
    assign opnd.rd_a  = rd_a_i;
    assign opnd.rs1_a = rs1_a_i;

    exec_alu u_alu (
        .opnd_i   (opnd.alu_mp),
        .alusel_i (alusel_i),
        .result_o (alu_res)
    );

    exec_branch_unit u_branch (
        .opnd_i       (opnd.branch_mp),
        .next_pc_i    (next_pc_i),
        .next_taken_i (next_taken_i),
        .branch_o     (br_info)
    );

    exec_mem_reg u_mem_reg (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .pc_i     (pc_i),
        .uop_i    (uop_i),
        .rd_we_i  (rd_we_i),
        .rd_a_i   (rd_a_i),
        .alu_i    (alu_res),
        .branch_i (br_info),
        .pc_o     (pc_o),
        .uop_o    (uop_o),
        .rd_we_o  (rd_we_o),
        .rd_a_o   (rd_a_o),
        .alu_o    (alu_q),
        .branch_o (br_q)
    );

    // registered results out to the memory stage
    assign rd_wd_o              = alu_q.rd_wd;
    assign mem_a_o              = alu_q.mem_a;
    assign mem_wd_o             = alu_q.mem_wd;
    assign branch_request_o     = br_q.request;
    assign branch_taken_o       = br_q.taken;
    assign branch_is_call_o     = br_q.is_call;
    assign branch_is_ret_o      = br_q.is_ret;
    assign branch_is_jmp_o      = br_q.is_jmp;
    assign branch_target_o      = br_q.target;
    assign branch_redirect_o    = br_q.redirect;
    assign branch_redirect_pc_o = br_q.redirect_pc;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_tb_rv_exec
log_file=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    -f rv_exec.f --top-module tb_rv_exec \
    --Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -x "All tests passed" "$log_file"; then
    exit 0
fi
echo "simulation reported failures, see $log_file"
exit 1

// ==== rv_exec.f ====
+incdir+logic
logic/rv_exec_pkg.sv
logic/exec_operand_if.sv
logic/exec_alu.sv
logic/exec_branch_unit.sv
logic/exec_mem_reg.sv
logic/rv_exec_top.sv
tests/tb_rv_exec.sv

// ==== tests/exec_patterns.mem ====
// uop_sel_pc_rs1d_rs2d_imm_rs1a_rda_ntaken_npc | rdwd_mema_memwd_flags_target_redirpc
// flags: request taken call ret jmp redirect, bit 5 down to bit 0
01_1_00001000_00000010_00000000_fffffffc_02_03_0_00001004_0000000c_00000000_00000000_00_00000000_00000000
02_1_00001004_7fffffff_00000001_00000000_02_04_0_00001008_80000000_00000000_00000000_00_00000000_00000000
03_1_00001008_00000005_00000007_00000000_02_05_0_0000100c_fffffffe_00000000_00000000_00_00000000_00000000
04_2_0000100c_00000000_00000000_12345000_00_06_0_00001010_12345000_00000000_00000000_00_00000000_00000000
05_2_00001010_00000000_00000000_00002000_00_07_0_00001014_00003010_00000000_00000000_00_00000000_00000000
0a_2_00001018_f0f0f0f0_0f0f0f0f_00000000_02_08_0_0000101c_ffffffff_00000000_00000000_00_00000000_00000000
0e_2_00001020_ffffffff_00000001_00000000_02_09_0_00001024_00000001_00000000_00000000_00_00000000_00000000
0f_2_00001024_ffffffff_00000001_00000000_02_0a_0_00001028_00000000_00000000_00000000_00_00000000_00000000
10_3_0000102c_00000001_00000000_0000001f_02_0b_0_00001030_80000000_00000000_00000000_00_00000000_00000000
15_3_00001030_80000000_00000024_00000000_02_0c_0_00001034_f8000000_00000000_00000000_00_00000000_00000000
12_3_00001038_fffffff0_00000000_00000002_02_0d_0_0000103c_fffffffc_00000000_00000000_00_00000000_00000000
1a_0_0000103c_00002000_12345678_fffffffc_02_0e_0_00001040_00000000_00001ffc_00000000_00_00000000_00000000
1d_0_00001044_00002000_deadbeef_00000008_02_00_0_00001048_00000000_00002008_deadbeef_00_00000000_00000000
1e_4_0000104c_00000000_00000000_00000100_00_01_1_0000114c_00001050_00000000_00000000_38_0000114c_00000000
1e_4_00001050_00000000_00000000_fffffff0_00_00_0_00001054_00001054_00000000_00000000_33_00001040_00001040
1f_4_00001054_00008000_00000000_00000004_06_01_1_00008004_00001058_00000000_00000000_38_00008004_00000000
1f_4_00001058_00001050_00000000_00000000_01_00_1_00001060_0000105c_00000000_00000000_35_00001050_00001050
1f_4_0000105c_00002001_00000000_00000003_05_01_1_00002004_00001060_00000000_00000000_3c_00002004_00000000
1f_4_00001060_00003000_00000000_00000001_05_05_1_00003001_00001064_00000000_00000000_38_00003001_00000000
1f_4_00001064_00004000_00000000_fffffffc_07_00_0_00001068_00001068_00000000_00000000_33_00003ffc_00003ffc
20_0_00001068_00000005_00000005_00000010_02_00_1_00001078_00000000_00000000_00000000_30_00001078_00000000
20_0_0000106c_00000005_00000006_00000010_02_00_0_00001070_00000000_00000000_00000000_20_0000107c_00000000
21_0_00001070_00000001_00000002_00000020_02_00_0_00001074_00000000_00000000_00000000_31_00001090_00001090
21_0_00001074_00000003_00000003_00000020_02_00_1_00001094_00000000_00000000_00000000_21_00001094_00001078
24_0_00001078_ffffffff_00000001_fffffff8_02_00_1_00001070_00000000_00000000_00000000_30_00001070_00000000
25_0_0000107c_ffffffff_00000001_fffffff8_02_00_0_00001080_00000000_00000000_00000000_20_00001074_00000000
22_0_00001080_80000000_00000000_00000040_02_00_0_00001084_00000000_00000000_00000000_20_000010c0_00000000
23_0_00001084_80000000_00000000_00000040_02_00_1_000010c8_00000000_00000000_00000000_31_000010c4_000010c4
22_0_00001088_00000000_ffffffff_00000008_02_00_1_00001090_00000000_00000000_00000000_30_00001090_00000000
24_0_0000108c_00000001_ffffffff_00000008_02_00_0_00001090_00000000_00000000_00000000_20_00001094_00000000
25_0_00001090_00000001_ffffffff_00000008_02_00_1_00001098_00000000_00000000_00000000_30_00001098_00000000
23_0_00001094_00000001_00000002_00000010_02_00_0_00001098_00000000_00000000_00000000_20_000010a4_00000000
00_0_00001098_00000000_00000000_00000000_00_00_0_0000109c_00000000_00000000_00000000_00_00000000_00000000

// ==== tests/tb_rv_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_macros.svh"

module tb_rv_exec import rv_exec_pkg::*; ();

    localparam int RESET_CYCLES = 4;
    localparam int MAX_PATTERNS = 64;
    localparam int PAT_W        = 360;

    // one line of the patterns file, fields in file order
    typedef struct packed {
        logic [7:0]       uop;
        logic [3:0]       alusel;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] rs1_d;
        logic [`XLEN-1:0] rs2_d;
        logic [`XLEN-1:0] imm;
        logic [7:0]       rs1_a;
        logic [7:0]       rd_a;
        logic [3:0]       next_taken;
        logic [`XLEN-1:0] next_pc;
        logic [`XLEN-1:0] rd_wd;
        logic [`XLEN-1:0] mem_a;
        logic [`XLEN-1:0] mem_wd;
        logic [7:0]       flags;      // request taken call ret jmp redirect
        logic [`XLEN-1:0] target;
        logic [`XLEN-1:0] redirect_pc;
    } pattern_t;

    logic                   clk_i;
    logic                   rst_i;
    logic [`XLEN-1:0]       pc_i;
    logic [`XLEN-1:0]       next_pc_i;
    logic                   next_taken_i;
    uop_e                   uop_i;
    exe_type_e              alusel_i;
    logic [`XLEN-1:0]       rs1_d_i;
    logic [`XLEN-1:0]       rs2_d_i;
    logic [`XLEN-1:0]       imm_i;
    logic [`REG_ADDR_W-1:0] rs1_a_i;
    logic                   rd_we_i;
    logic [`REG_ADDR_W-1:0] rd_a_i;
    logic [`XLEN-1:0]       pc_o;
    uop_e                   uop_o;
    logic                   rd_we_o;
    logic [`REG_ADDR_W-1:0] rd_a_o;
    logic [`XLEN-1:0]       rd_wd_o;
    logic [`XLEN-1:0]       mem_a_o;
    logic [`XLEN-1:0]       mem_wd_o;
    logic                   branch_request_o;
    logic                   branch_taken_o;
    logic                   branch_is_call_o;
    logic                   branch_is_ret_o;
    logic                   branch_is_jmp_o;
    logic [`XLEN-1:0]       branch_target_o;
    logic                   branch_redirect_o;
    logic [`XLEN-1:0]       branch_redirect_pc_o;

    logic [PAT_W-1:0] pattern_mem [0:MAX_PATTERNS-1];
    pattern_t         rec;
    pattern_t         prev;
    int               num_patterns;
    int               error_count;
    int               check_count;
    int               cycle_limit;
    int               cycle_count = 0;

    rv_exec_top uut (
        .clk_i(clk_i), .rst_i(rst_i),
        .pc_i(pc_i), .next_pc_i(next_pc_i), .next_taken_i(next_taken_i),
        .uop_i(uop_i), .alusel_i(alusel_i),
        .rs1_d_i(rs1_d_i), .rs2_d_i(rs2_d_i), .imm_i(imm_i), .rs1_a_i(rs1_a_i),
        .rd_we_i(rd_we_i), .rd_a_i(rd_a_i),
        .pc_o(pc_o), .uop_o(uop_o), .rd_we_o(rd_we_o), .rd_a_o(rd_a_o), .rd_wd_o(rd_wd_o),
        .mem_a_o(mem_a_o), .mem_wd_o(mem_wd_o),
        .branch_request_o(branch_request_o), .branch_taken_o(branch_taken_o),
        .branch_is_call_o(branch_is_call_o), .branch_is_ret_o(branch_is_ret_o),
        .branch_is_jmp_o(branch_is_jmp_o), .branch_target_o(branch_target_o),
        .branch_redirect_o(branch_redirect_o), .branch_redirect_pc_o(branch_redirect_pc_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_uop(input string name, input uop_e exp, input uop_e act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAIL %s: expected %s (%h), actual %s (%h)", name,
                     exp.name(), exp, act.name(), act);
        end
    endtask

    task automatic drive_pattern(input pattern_t p);
        uop_i        = uop_e'(p.uop[`UOP_W-1:0]);
        alusel_i     = exe_type_e'(p.alusel[2:0]);
        pc_i         = p.pc;
        rs1_d_i      = p.rs1_d;
        rs2_d_i      = p.rs2_d;
        imm_i        = p.imm;
        rs1_a_i      = p.rs1_a[`REG_ADDR_W-1:0];
        rd_a_i       = p.rd_a[`REG_ADDR_W-1:0];
        rd_we_i      = (p.rd_a != 8'h00);   // x0 is never written
        next_taken_i = p.next_taken[0];
        next_pc_i    = p.next_pc;
    endtask

    // busy inputs during reset so that the reset values are visible
    function automatic pattern_t reset_stimulus(input int cycle);
        pattern_t p;
        p         = '0;
        p.pc      = 32'h0000_0100;
        p.rs1_d   = 32'h0000_0200;
        p.rs2_d   = 32'h5a5a_5a5a;
        p.imm     = 32'h0000_0004;
        p.rs1_a   = 8'h05;
        p.rd_a    = 8'h01;
        p.next_pc = 32'h0000_0300;
        case (cycle % 3)
            1: begin
                p.uop    = 8'(UOP_JALR);     // call and ret, mispredicted
                p.alusel = 4'(EXE_BRANCH);
            end
            2: begin
                p.uop    = 8'(UOP_JAL);      // rd x0 gives a plain jump
                p.rd_a   = 8'h00;
                p.alusel = 4'(EXE_BRANCH);
            end
            default: begin
                p.uop    = 8'(UOP_SW);
                p.alusel = 4'(EXE_NONE);
            end
        endcase
        return p;
    endfunction

    task automatic check_reset_outputs(input int cycle);
        string name;
        name = $sformatf("reset cycle %0d", cycle);
        check_uop({name, " uop"}, UOP_NOP, uop_o);
        check_bit({name, " rd_we"}, 1'b0, rd_we_o);
        check_bit({name, " request"}, 1'b0, branch_request_o);
        check_bit({name, " taken"}, 1'b0, branch_taken_o);
        check_bit({name, " call"}, 1'b0, branch_is_call_o);
        check_bit({name, " ret"}, 1'b0, branch_is_ret_o);
        check_bit({name, " jmp"}, 1'b0, branch_is_jmp_o);
        check_bit({name, " redirect"}, 1'b0, branch_redirect_o);
        check_word({name, " pc"}, '0, pc_o);
        check_word({name, " rd_a"}, '0, {{(`XLEN-`REG_ADDR_W){1'b0}}, rd_a_o});
        check_word({name, " rd_wd"}, '0, rd_wd_o);
        check_word({name, " mem_a"}, '0, mem_a_o);
        check_word({name, " mem_wd"}, '0, mem_wd_o);
        check_word({name, " target"}, '0, branch_target_o);
        check_word({name, " redirect_pc"}, '0, branch_redirect_pc_o);
    endtask

    task automatic check_pattern(input int idx, input pattern_t p);
        string name;
        uop_e  exp_uop;
        exp_uop = uop_e'(p.uop[`UOP_W-1:0]);
        name    = $sformatf("pattern %0d %s", idx, exp_uop.name());
        check_word({name, " pc"}, p.pc, pc_o);
        check_uop({name, " uop"}, exp_uop, uop_o);
        check_bit({name, " rd_we"}, (p.rd_a != 8'h00), rd_we_o);
        check_word({name, " rd_a"}, {24'h0, p.rd_a},
                   {{(`XLEN-`REG_ADDR_W){1'b0}}, rd_a_o});
        check_word({name, " rd_wd"}, p.rd_wd, rd_wd_o);
        check_word({name, " mem_a"}, p.mem_a, mem_a_o);
        check_word({name, " mem_wd"}, p.mem_wd, mem_wd_o);
        check_bit({name, " request"}, p.flags[5], branch_request_o);
        check_bit({name, " taken"}, p.flags[4], branch_taken_o);
        check_bit({name, " call"}, p.flags[3], branch_is_call_o);
        check_bit({name, " ret"}, p.flags[2], branch_is_ret_o);
        check_bit({name, " jmp"}, p.flags[1], branch_is_jmp_o);
        check_bit({name, " redirect"}, p.flags[0], branch_redirect_o);
        check_word({name, " target"}, p.target, branch_target_o);
        check_word({name, " redirect_pc"}, p.redirect_pc, branch_redirect_pc_o);
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        drive_pattern('0);
        error_count  = 0;
        check_count  = 0;
        num_patterns = 0;
        cycle_limit  = RESET_CYCLES + 20;

        // unused entries keep uop ff, which marks the end of the list
        for (int i = 0; i < MAX_PATTERNS; i++) begin
            pattern_mem[i] = {8'hff, (PAT_W-8)'(i)};
        end
        $readmemh("tests/exec_patterns.mem", pattern_mem);
        while (num_patterns < MAX_PATTERNS && pattern_mem[num_patterns][PAT_W-1 -: 8] != 8'hff)
            num_patterns++;
        cycle_limit = RESET_CYCLES + num_patterns + 20;
        if (num_patterns == 0) begin
            error_count++;
            $display("no patterns could be read from tests/exec_patterns.mem");
        end

        for (int c = 1; c <= RESET_CYCLES; c++) begin
            drive_pattern(reset_stimulus(c));
            @(negedge clk_i);
            check_reset_outputs(c);
        end
        rst_i = 1'b0;

        // drive one pattern per cycle, check the one before it
        for (int i = 0; i < num_patterns; i++) begin
            if (i > 0) begin
                @(negedge clk_i);
                check_pattern(i - 1, prev);
            end
            rec = pattern_t'(pattern_mem[i]);
            drive_pattern(rec);
            prev = rec;
        end
        if (num_patterns > 0) begin
            @(negedge clk_i);
            check_pattern(num_patterns - 1, prev);
        end

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
